// ==== Makefile ====
SIM = obj_dir/adpcma_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module adpcma_tb -f verilog.f -Mdir obj_dir -o adpcma_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/adpcma_addr_fsm.sv ====
/* Per-channel play state, start/end registers and byte counter.
   Presents one ROM fetch per step for the channel named by slot. */
module adpcma_addr_fsm (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  logic [2:0]  slot,
    input  logic        key_on,
    input  logic        key_off,
    input  logic        st_wr,
    input  logic        end_wr,
    input  logic [11:0] addr_in,
    output logic [19:0] addr,
    output logic        nibble_sel,
    output logic        roe_n,
    output logic        dec_reset
);
    import adpcma_pkg::*;

    ch_state_e   state_r [num_slots];
    logic [11:0] start_r [num_slots];   // 256-byte units
    logic [11:0] end_r   [num_slots];
    logic [19:0] cnt_r   [num_slots];   // byte address counter
    logic        phase_r [num_slots];   // 0 high nibble, 1 low nibble

    logic playing;
    logic past_end;
    logic fetch;

    assign playing  = (state_r[slot] == ch_play);
    assign past_end = playing && (cnt_r[slot] > {end_r[slot], 8'hff});
    assign fetch    = playing && !key_on && !key_off && !past_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_slots; i++) begin
                state_r[i] <= ch_idle;
            end
            addr       <= 20'd0;
            nibble_sel <= 1'b0;
            roe_n      <= 1'b1;
            dec_reset  <= 1'b0;
        end else if (cen) begin
            dec_reset <= key_on;                        // predictor clear rides the pipe
            roe_n     <= 1'b1;                          // no fetch unless playing
            if (key_on) begin
                state_r[slot] <= ch_play;
            end else if (key_off || past_end) begin
                state_r[slot] <= ch_idle;
            end else if (fetch) begin
                addr       <= cnt_r[slot];
                nibble_sel <= ~phase_r[slot];           // high nibble first
                roe_n      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (st_wr)  start_r[slot] <= addr_in;
            if (end_wr) end_r[slot]   <= addr_in;
            if (key_on) begin
                cnt_r[slot]   <= {start_r[slot], 8'h00};
                phase_r[slot] <= 1'b0;
            end else if (fetch) begin
                phase_r[slot] <= ~phase_r[slot];
                if (phase_r[slot]) cnt_r[slot] <= cnt_r[slot] + 20'd1;  // after low nibble
            end
        end
    end

endmodule

// ==== hdl/adpcma_decoder.sv ====
/* ADPCM-A nibble decoder, time-multiplexed over six channels.
   Keeps predictor and step index per channel, one update per step. */
module adpcma_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cen,
    input  logic [3:0]                           nibble,
    input  logic                                 nib_valid,
    input  logic                                 dec_reset_in,
    input  logic [2:0]                           slot_in,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm,
    output logic [2:0]                           slot_out
);
    import adpcma_pkg::*;

    logic signed [15:0] acc_r [num_slots];   // predictor, kept within +-2047
    logic [5:0]         idx_r [num_slots];   // step index 0..48

    logic [11:0]        step;
    logic [12:0]        delta;
    logic signed [16:0] acc_sum;
    logic signed [15:0] acc_sat;
    logic signed [6:0]  idx_sum;
    logic [5:0]         idx_new;

    always_comb begin
        step  = step_table[idx_r[slot_in]];
        delta = 13'(step >> 3);
        if (nibble[2]) delta = delta + 13'(step);
        if (nibble[1]) delta = delta + 13'(step >> 1);
        if (nibble[0]) delta = delta + 13'(step >> 2);

        acc_sum = nibble[3] ? acc_r[slot_in] - $signed({4'd0, delta})
                            : acc_r[slot_in] + $signed({4'd0, delta});
        if (acc_sum > 17'sd2047)       acc_sat = 16'sd2047;
        else if (acc_sum < -17'sd2047) acc_sat = -16'sd2047;
        else                           acc_sat = acc_sum[15:0];

        idx_sum = $signed({1'b0, idx_r[slot_in]}) + index_adj[nibble[2:0]];
        if (idx_sum < 7'sd0)       idx_new = 6'd0;
        else if (idx_sum > 7'sd48) idx_new = 6'd48;
        else                       idx_new = idx_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_slots; i++) begin
                acc_r[i] <= 16'sd0;
                idx_r[i] <= 6'd0;
            end
            pcm      <= '0;
            slot_out <= 3'd0;
        end else if (cen) begin
            slot_out <= slot_in;
            pcm      <= '0;                       // idle or reset slot is silent
            if (dec_reset_in) begin
                acc_r[slot_in] <= 16'sd0;
                idx_r[slot_in] <= 6'd0;
            end else if (nib_valid) begin
                acc_r[slot_in] <= acc_sat;
                idx_r[slot_in] <= idx_new;
                pcm            <= acc_sat <<< 4;  // 12-bit to 16-bit scale
            end
        end
    end

endmodule

// ==== hdl/adpcma_drv.sv ====
/* Top level of the six-channel ADPCM-A playback engine.
   Latches the ROM nibble and chains timer, address FSM, decoder, gain and mixer. */
module adpcma_drv (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cen,
    input  logic                                 aon_up,
    input  logic [7:0]                           aon_cmd,
    input  logic [5:0]                           atl,
    input  logic [7:0]                           lracl_in,
    input  logic [11:0]                          addr_in,
    input  logic [2:0]                           up_lracl,
    input  logic [2:0]                           up_start,
    input  logic [2:0]                           up_end,
    input  logic [7:0]                           datain,
    output logic [19:0]                          addr,
    output logic                                 roe_n,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_l,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_r
);
    import adpcma_pkg::*;

    logic [2:0] slot;
    logic       key_on, key_off, st_wr, end_wr;
    logic       nibble_sel, dec_reset;

    logic [2:0] fetch_slot;       // slot tag aligned with addr
    logic [3:0] nibble;
    logic       nib_valid;
    logic       nib_rst;
    logic [2:0] nib_slot;

    logic signed [pcm_w-1:0] pcm_dec, gain_l, gain_r;
    logic [2:0]              dec_slot, gain_slot;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_slot <= 3'd0;
            nibble     <= 4'd0;
            nib_valid  <= 1'b0;
            nib_rst    <= 1'b0;
            nib_slot   <= 3'd0;
        end else if (cen) begin
            fetch_slot <= slot;
            nib_valid  <= ~roe_n;
            nibble     <= roe_n ? 4'd0 : (nibble_sel ? datain[7:4] : datain[3:0]);
            nib_rst    <= dec_reset;
            nib_slot   <= fetch_slot;
        end
    end

    adpcma_slot_timer u_timer (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .aon_up(aon_up), .aon_cmd(aon_cmd),
        .up_start(up_start), .up_end(up_end),
        .slot(slot), .key_on(key_on), .key_off(key_off),
        .st_wr(st_wr), .end_wr(end_wr)
    );

    adpcma_addr_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .cen(cen), .slot(slot),
        .key_on(key_on), .key_off(key_off), .st_wr(st_wr), .end_wr(end_wr),
        .addr_in(addr_in), .addr(addr), .nibble_sel(nibble_sel),
        .roe_n(roe_n), .dec_reset(dec_reset)
    );

    adpcma_decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .nibble(nibble), .nib_valid(nib_valid), .dec_reset_in(nib_rst),
        .slot_in(nib_slot), .pcm(pcm_dec), .slot_out(dec_slot)
    );

    adpcma_gain u_gain (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .atl(atl), .lracl_in(lracl_in), .up_lracl(up_lracl),
        .pcm_in(pcm_dec), .slot_in(dec_slot),
        .pcm_l(gain_l), .pcm_r(gain_r), .slot_out(gain_slot)
    );

    adpcma_mix u_mix (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .pcm_l_in(gain_l), .pcm_r_in(gain_r), .slot_in(gain_slot),
        .pcm_l(pcm_l), .pcm_r(pcm_r)
    );

endmodule

// ==== hdl/adpcma_gain.sv ====
/* Per-channel pan/level bytes, total-level scaling and left/right routing.
   One decoded sample in, one stereo pair out per step. */
module adpcma_gain (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cen,
    input  logic [5:0]                           atl,
    input  logic [7:0]                           lracl_in,
    input  logic [2:0]                           up_lracl,
    input  logic signed [adpcma_pkg::pcm_w-1:0] pcm_in,
    input  logic [2:0]                           slot_in,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_l,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_r,
    output logic [2:0]                           slot_out
);
    import adpcma_pkg::*;

    logic [7:0]         lracl_r [num_slots];   // bit7 left, bit6 right, 4..0 level
    logic [7:0]         cur;
    logic signed [7:0]  atl_f;                 // atl + 1, up to 64
    logic signed [6:0]  lvl_f;                 // level + 1, up to 32
    logic signed [29:0] prod;
    logic signed [29:0] scaled;

    assign cur    = lracl_r[slot_in];
    assign atl_f  = $signed({2'b00, atl}) + 8'sd1;
    assign lvl_f  = $signed({2'b00, cur[4:0]}) + 7'sd1;
    assign prod   = pcm_in * atl_f * lvl_f;
    assign scaled = prod >>> 11;               // full scale back to 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_slots; i++) begin
                lracl_r[i] <= 8'd0;
            end
            pcm_l    <= '0;
            pcm_r    <= '0;
            slot_out <= 3'd0;
        end else if (cen) begin
            if (up_lracl == slot_in) lracl_r[slot_in] <= lracl_in;   // takes effect next round
            pcm_l    <= cur[7] ? scaled[15:0] : '0;
            pcm_r    <= cur[6] ? scaled[15:0] : '0;
            slot_out <= slot_in;
        end
    end

endmodule

// ==== hdl/adpcma_mix.sv ====
/* Stereo round mixer: sums the six slot samples per side.
   Saturated total is output on the slot-5 sample and held for a round. */
module adpcma_mix (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cen,
    input  logic signed [adpcma_pkg::pcm_w-1:0] pcm_l_in,
    input  logic signed [adpcma_pkg::pcm_w-1:0] pcm_r_in,
    input  logic [2:0]                           slot_in,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_l,
    output logic signed [adpcma_pkg::pcm_w-1:0] pcm_r
);
    import adpcma_pkg::*;

    logic signed [18:0] acc_l, acc_r;     // six 16-bit samples need 19 bits
    logic signed [18:0] sum_l, sum_r;
    logic               round_end;

    assign sum_l     = acc_l + pcm_l_in;
    assign sum_r     = acc_r + pcm_r_in;
    assign round_end = (slot_in == 3'(num_slots - 1));

    function automatic logic signed [15:0] sat16(input logic signed [18:0] v);
        if (v > 19'sd32767)       return 16'sh7fff;
        else if (v < -19'sd32768) return 16'sh8000;
        else                      return v[15:0];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l <= 19'sd0;
            acc_r <= 19'sd0;
            pcm_l <= '0;
            pcm_r <= '0;
        end else if (cen) begin
            if (round_end) begin
                pcm_l <= sat16(sum_l);    // includes the slot 5 sample
                pcm_r <= sat16(sum_r);
                acc_l <= 19'sd0;
                acc_r <= 19'sd0;
            end else begin
                acc_l <= sum_l;
                acc_r <= sum_r;
            end
        end
    end

endmodule

// ==== hdl/adpcma_pkg.sv ====
/* Constants, decoder tables and channel state type for the ADPCM-A playback engine.
   Imported by every RTL module of the engine. */
package adpcma_pkg;

    localparam int num_slots = 6;            // channels per round
    localparam logic [2:0] no_ch = 3'd7;     // idle value on update strobes
    localparam int pcm_w = 16;               // decoder sample width

    // standard ADPCM-A step sizes, 49 entries
    localparam logic [11:0] step_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // step index change, picked by nibble bits 2..0
    localparam logic signed [4:0] index_adj [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

    typedef enum logic {
        ch_idle,
        ch_play
    } ch_state_e;

endpackage

// ==== hdl/adpcma_slot_timer.sv ====
/* Slot counter plus key-on/key-off rings and start/end write strobes.
   Each command comes out in the step whose slot equals its channel. */
module adpcma_slot_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic       aon_up,
    input  logic [7:0] aon_cmd,
    input  logic [2:0] up_start,
    input  logic [2:0] up_end,
    output logic [2:0] slot,
    output logic       key_on,
    output logic       key_off,
    output logic       st_wr,
    output logic       end_wr
);
    import adpcma_pkg::*;

    logic [5:0] pend_mask;        // key mask waiting for round end
    logic       pend_off;         // aon_cmd bit 7, off when set
    logic [5:0] on_ring;
    logic [5:0] off_ring;
    logic       last_slot;

    assign last_slot = (slot == 3'(num_slots - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot      <= 3'd0;
            pend_mask <= 6'd0;
            pend_off  <= 1'b0;
            on_ring   <= 6'd0;
            off_ring  <= 6'd0;
        end else begin
            if (cen) begin
                slot     <= last_slot ? 3'd0 : slot + 3'd1;
                on_ring  <= {1'b0, on_ring[5:1]};    // bit 0 tracks current slot
                off_ring <= {1'b0, off_ring[5:1]};
                if (last_slot) begin
                    if (pend_off) off_ring <= pend_mask;
                    else          on_ring  <= pend_mask;
                    pend_mask <= 6'd0;               // one-shot per command
                end
            end
            if (aon_up) begin                        // new command wins over the clear
                pend_mask <= aon_cmd[5:0];
                pend_off  <= aon_cmd[7];
            end
        end
    end

    assign key_on  = on_ring[0];
    assign key_off = off_ring[0];
    assign st_wr   = (up_start != no_ch) && (up_start == slot);
    assign end_wr  = (up_end != no_ch) && (up_end == slot);

endmodule

// ==== verif/adpcma_tb.sv ====
/* Testbench for the ADPCM-A playback engine with a random ROM and a round reference model.
   Compares each stereo round output and every ROM fetch address against the model. */
module adpcma_tb;
    localparam int total_rounds = 800;                 // all tests plus slack
    localparam int limit = total_rounds * 12 * 16 + 2000;

    logic clk, rst_n, cen, aon_up;
    logic [7:0] aon_cmd, lracl_in, datain;
    logic [5:0] atl;
    logic [11:0] addr_in;
    logic [2:0] up_lracl, up_start, up_end;
    logic [19:0] addr;
    logic roe_n;
    logic signed [15:0] pcm_l, pcm_r;

    logic [7:0] rom [65536];
    int steps [49] = '{16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337, 371,
        408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552};
    int adj [8] = '{-1, -1, -1, -1, 2, 5, 7, 9};

    // model state per channel
    bit m_play [6];
    bit m_phase [6];
    int m_cnt [6], m_start [6], m_end [6], m_acc [6], m_idx [6];
    logic [7:0] m_lracl [6];
    logic [5:0] m_pend;
    bit m_pend_off;
    int m_atl;

    int tb_slot, errs, checks, tests, failed, test_errs, fa;
    int exp_addr [$];
    logic [31:0] expect_q [$];
    logic [31:0] exp_pair;
    logic signed [15:0] first_run [12];               // model left output of the first play

    adpcma_drv u_dut (
        .clk(clk), .rst_n(rst_n), .cen(cen), .aon_up(aon_up), .aon_cmd(aon_cmd),
        .atl(atl), .lracl_in(lracl_in), .addr_in(addr_in), .up_lracl(up_lracl),
        .up_start(up_start), .up_end(up_end), .datain(datain), .addr(addr),
        .roe_n(roe_n), .pcm_l(pcm_l), .pcm_r(pcm_r)
    );

    assign datain = rom[addr[15:0]];                   // combinational ROM

    always #4 clk = ~clk;
    always @(posedge clk) cen <= ~cen;                 // one step every two clocks

    function automatic int clamp16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // one full round of fetch, decode, gain and mix
    function automatic logic [31:0] round_model();
        int sum_l, sum_r, st, delta, p, lvl, sl, sr;
        logic [7:0] b;
        logic [3:0] n;
        logic [5:0] on_m, off_m;
        on_m = m_pend_off ? 6'd0 : m_pend;
        off_m = m_pend_off ? m_pend : 6'd0;
        m_pend = 6'd0;
        sum_l = 0;
        sum_r = 0;
        for (int c = 0; c < 6; c++) begin
            if (on_m[c]) begin
                m_play[c] = 1;
                m_cnt[c] = m_start[c] * 256;
                m_phase[c] = 0;
                m_acc[c] = 0;
                m_idx[c] = 0;
            end else if (off_m[c]) begin
                m_play[c] = 0;
            end else if (m_play[c] && m_cnt[c] > m_end[c] * 256 + 255) begin
                m_play[c] = 0;                          // ran past end
            end else if (m_play[c]) begin
                exp_addr.push_back(m_cnt[c]);
                b = rom[m_cnt[c]];
                n = m_phase[c] ? b[3:0] : b[7:4];
                if (m_phase[c]) m_cnt[c]++;
                m_phase[c] = !m_phase[c];
                st = steps[m_idx[c]];
                delta = st / 8;
                if (n[2]) delta += st;
                if (n[1]) delta += st / 2;
                if (n[0]) delta += st / 4;
                m_acc[c] = n[3] ? m_acc[c] - delta : m_acc[c] + delta;
                if (m_acc[c] > 2047) m_acc[c] = 2047;
                if (m_acc[c] < -2047) m_acc[c] = -2047;
                m_idx[c] += adj[n[2:0]];
                if (m_idx[c] < 0) m_idx[c] = 0;
                if (m_idx[c] > 48) m_idx[c] = 48;
                lvl = m_lracl[c][4:0];
                p = m_acc[c] * 16 * (m_atl + 1) * (lvl + 1);
                p = p >>> 11;
                if (m_lracl[c][7]) sum_l += p;
                if (m_lracl[c][6]) sum_r += p;
            end
        end
        sl = clamp16(sum_l);
        sr = clamp16(sum_r);
        return {sl[15:0], sr[15:0]};
    endfunction

    // step tracking, fetch address and output compare
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tb_slot <= 0;
        end else if (cen) begin
            tb_slot <= (tb_slot == 5) ? 0 : tb_slot + 1;
            if (!roe_n) begin
                if (exp_addr.size() == 0) begin
                    errs++;
                    $display("unexpected ROM fetch at address %0h, time %0t", addr, $time);
                end else begin
                    fa = exp_addr.pop_front();
                    checks++;
                    if (addr != 20'(fa)) begin
                        errs++;
                        $display("FAIL %0t: addr %0h expected %0h", $time, addr, fa);
                    end
                end
            end
            if (tb_slot == 0) begin
                if (exp_addr.size() != 0) begin
                    errs++;
                    $display("%0d ROM fetches missing at time %0t", exp_addr.size(), $time);
                    exp_addr.delete();
                end
                expect_q.push_back(round_model());
            end
            if (tb_slot == 4 && expect_q.size() >= 2) begin
                exp_pair = expect_q.pop_front();   // output of the round before last
                checks++;
                if (pcm_l != exp_pair[31:16]) begin
                    errs++;
                    $display("FAIL %0t: pcm_l %0d expected %0d", $time, pcm_l,
                             $signed(exp_pair[31:16]));
                end
                if (pcm_r != exp_pair[15:0]) begin
                    errs++;
                    $display("FAIL %0t: pcm_r %0d expected %0d", $time, pcm_r,
                             $signed(exp_pair[15:0]));
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        while (!cen) @(posedge clk);
    endtask

    task automatic wait_rounds(input int n);
        repeat (n * 6) step();
    endtask

    task automatic key_cmd(input logic [5:0] mask, input bit off);
        step();
        while (tb_slot != 2) step();                 // well away from round end
        aon_up <= 1'b1;
        aon_cmd <= {off, 1'b0, mask};
        m_pend = mask;
        m_pend_off = off;
        @(posedge clk);
        aon_up <= 1'b0;
    endtask

    task automatic config_channel(input int c, input int st, input int en, input logic [7:0] lr);
        up_start <= 3'(c);
        up_lracl <= 3'(c);
        addr_in <= 12'(st);
        lracl_in <= lr;
        repeat (7) step();
        up_start <= 3'd7;
        up_lracl <= 3'd7;
        up_end <= 3'(c);
        addr_in <= 12'(en);
        repeat (7) step();
        up_end <= 3'd7;
        m_start[c] = st;
        m_end[c] = en;
        m_lracl[c] = lr;
    endtask

    task automatic quiesce();
        key_cmd(6'h3f, 1'b1);
        wait_rounds(3);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errs != test_errs) failed++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errs == test_errs) ? "ok" : "bad", errs - test_errs);
        test_errs = errs;
    endtask

    initial begin
        void'($urandom(32'hc825_0914));
        for (int i = 0; i < 65536; i++) rom[i] = 8'($urandom);
        clk = 0;
        rst_n = 0;
        cen = 0;
        aon_up = 0;
        aon_cmd = 0;
        atl = 0;
        lracl_in = 0;
        addr_in = 0;
        up_lracl = 3'd7;
        up_start = 3'd7;
        up_end = 3'd7;
        m_pend = 0;
        m_pend_off = 0;
        m_atl = 0;
        errs = 0;
        checks = 0;
        tests = 0;
        failed = 0;
        test_errs = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        wait_rounds(20);                               // idle with no fetch and silent
        end_test("idle after reset");

        atl <= 6'd63;
        m_atl = 63;
        config_channel(1, 3, 200, 8'hdf);
        key_cmd(6'h02, 1'b0);
        wait_rounds(40);
        end_test("single channel");

        quiesce();
        m_atl = 32 + ($urandom % 32);
        atl <= 6'(m_atl);
        for (int c = 0; c < 6; c++)
            config_channel(c, $urandom % 100, 150, 8'($urandom) & 8'hdf);
        key_cmd(6'h3f, 1'b0);
        wait_rounds(60);
        end_test("six channels");

        key_cmd(6'h15, 1'b1);
        wait_rounds(30);
        end_test("partial key-off");

        quiesce();
        config_channel(4, 20, 20, 8'hdf);
        key_cmd(6'h10, 1'b0);
        wait_rounds(525);                              // 512 rounds to pass the end
        end_test("end address");

        quiesce();
        config_channel(2, 50, 80, 8'hd8);
        key_cmd(6'h04, 1'b0);
        wait_rounds(2);
        for (int k = 0; k < 12; k++) begin
            wait_rounds(1);
            first_run[k] = exp_pair[31:16];            // model value of the round on pcm_l
        end
        key_cmd(6'h04, 1'b0);
        wait_rounds(2);
        for (int k = 0; k < 12; k++) begin
            wait_rounds(1);
            checks++;
            if (pcm_l != first_run[k]) begin
                errs++;
                $display("FAIL %0t: replay round %0d gives %0d, first play %0d",
                         $time, k, pcm_l, first_run[k]);
            end
        end
        end_test("re-key restart");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errs);
        if (errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(limit);
        $display("timeout: the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/adpcma_pkg.sv
hdl/adpcma_slot_timer.sv
hdl/adpcma_addr_fsm.sv
hdl/adpcma_decoder.sv
hdl/adpcma_gain.sv
hdl/adpcma_mix.sv
hdl/adpcma_drv.sv
verif/adpcma_tb.sv
